//--- tb.f
+incdir+.
uart_tx_pkg.sv
uart_tx_fifo.sv
uart_baud_counter.sv
uart_tx_datapath.sv
uart_tx_controller.sv
uart_tx_top.sv
tb_uart_tx.sv

//--- Bender.yml
package:
  name: uart_tx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uart_tx_pkg.sv
      - uart_tx_fifo.sv
      - uart_baud_counter.sv
      - uart_tx_datapath.sv
      - uart_tx_controller.sv
      - uart_tx_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart_tx.sv

//--- tb_uart_tx.sv
// ======================================
// UART transmitter testbench
// ======================================
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module tb_uart_tx;

    localparam int CLKS         = `UART_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 10 * CLKS;
    localparam int WAIT_LIMIT   = 40 * FRAME_CYCLES;
    localparam int BURST_LEN    = 40;

    logic                     clk;
    logic                     reset_b;
    uart_tx_pkg::tx_host_wr_t wr;
    logic                     wr_ack;
    logic                     tx;
    logic                     busy;

    uart_tx_pkg::tx_byte_t expected_q[$];  // Bytes accepted by the FIFO, oldest first
    logic [31:0]           rng_state;
    int                    error_count;
    int                    check_count;
    int                    pushed_count;
    int                    frames_started;
    bit                    stall_seen;     // Host had to wait on a full FIFO

    uart_tx_top u_dut (
        .clk     (clk),
        .reset_b (reset_b),
        .wr      (wr),
        .wr_ack  (wr_ack),
        .tx      (tx),
        .busy    (busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] draw_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic finish_run(input bit timed_out);
        $display("Checks %0d, errors %0d, bytes still expected %0d",
                 check_count, error_count, expected_q.size());
        if (error_count == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        finish_run(1'b1);
    endtask

    task automatic check_byte(input uart_tx_pkg::tx_byte_t got, input uart_tx_pkg::tx_byte_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t ns: byte 0x%02h on tx, expected 0x%02h", $time, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_period(input string what, input int measured);
        check_count++;
        if (measured == 0 || measured % CLKS != 0) begin
            error_count++;
            $display("Fail at %0t ns: %s lasted %0d cycles, expected a multiple of %0d",
                     $time, what, measured, CLKS);
        end
    endtask

    // Four-phase write of one byte, driven on the rising edge
    task automatic send_byte(input uart_tx_pkg::tx_byte_t value);
        int waited;
        @(posedge clk);
        wr.req  <= 1'b1;
        wr.data <= value;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (wr_ack !== 1'b1 && waited < WAIT_LIMIT);
        if (wr_ack !== 1'b1) begin
            report_timeout("wr_ack to rise");
        end else begin
            if (waited > CLKS) begin
                stall_seen = 1'b1;
            end
            expected_q.push_back(value);
            pushed_count++;
            check_count++;
            if (pushed_count - frames_started > `UART_FIFO_DEPTH + 1) begin  // Depth plus one in fetch
                error_count++;
                $display("Fail at %0t ns: %0d bytes accepted ahead of the line, limit %0d",
                         $time, pushed_count - frames_started, `UART_FIFO_DEPTH + 1);
            end
            wr.req <= 1'b0;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (wr_ack !== 1'b0 && waited < WAIT_LIMIT);
            if (wr_ack !== 1'b0) begin
                report_timeout("wr_ack to fall");
            end
        end
    endtask

    task automatic host_stream(input int count, input int max_gap);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = draw_random();
            send_byte(r[7:0]);
            repeat (r[15:8] % (max_gap + 1)) @(posedge clk);
        end
    endtask

    // Line model that rebuilds each frame from mid-bit samples
    task automatic decode_frames(input int count);
        uart_tx_pkg::tx_byte_t data;
        logic                  level;
        logic                  prev;
        int                    run;
        int                    waited;
        int                    idx;
        for (int f = 0; f < count; f++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (tx !== 1'b0 && waited < WAIT_LIMIT);
            if (tx !== 1'b0) begin
                report_timeout("a start bit on tx");
            end else begin
                frames_started++;
                prev = 1'b0;
                run  = 0;
                data = '0;
                for (int i = 0; i < FRAME_CYCLES; i++) begin
                    if (i > 0) begin
                        @(posedge clk);
                    end
                    level = tx;
                    if (level !== prev) begin
                        check_period("bit run", run);  // Every run spans whole bits
                        run  = 0;
                        prev = level;
                    end
                    run++;
                    if (i % CLKS == CLKS / 2) begin
                        idx = i / CLKS;
                        if (idx == 0) begin
                            check_bit("start bit", level, 1'b0);
                        end else if (idx == 9) begin
                            check_bit("stop bit", level, 1'b1);
                        end else begin
                            data[idx-1] = level;
                        end
                    end
                end
                check_period("stop bit", run);
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("Byte 0x%02h came out at %0t ns but none was written",
                             data, $time);
                end else begin
                    check_byte(data, expected_q.pop_front());
                end
            end
        end
    endtask

    task automatic check_idle_line(input string phase);
        repeat (2 * CLKS) begin
            @(posedge clk);
            check_bit({"tx ", phase}, tx, 1'b1);
            check_bit({"busy ", phase}, busy, 1'b0);
            check_bit({"wr_ack ", phase}, wr_ack, 1'b0);
        end
    endtask

    initial begin
        int waited;
        reset_b        = 1'b0;
        wr             = '0;
        rng_state      = 32'hf5ee;
        error_count    = 0;
        check_count    = 0;
        pushed_count   = 0;
        frames_started = 0;
        stall_seen     = 1'b0;
        repeat (16) @(posedge clk);
        reset_b <= 1'b1;
        check_idle_line("after reset");

        fork
            host_stream(1, 20);
            decode_frames(1);
        join

        // Short gaps keep the FIFO filling faster than the line drains
        fork
            host_stream(BURST_LEN, 3);
            decode_frames(BURST_LEN);
        join
        if (!stall_seen) begin
            error_count++;
            $display("The burst never filled the FIFO, so back-pressure went untested");
        end
        if (expected_q.size() != 0) begin
            error_count++;
            $display("Bytes lost or duplicated, %0d written and %0d left unmatched",
                     pushed_count, expected_q.size());
        end

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (busy !== 1'b0 && waited < WAIT_LIMIT);
        if (busy !== 1'b0) begin
            report_timeout("busy to fall");
        end else begin
            check_idle_line("after last frame");
            finish_run(1'b0);
        end
    end

endmodule

//--- uart_tx_top.sv
// ======================================
// UART transmitter top level
// ======================================
`timescale 1ns/1ps

module uart_tx_top (
    input  logic                     clk,
    input  logic                     reset_b,
    input  uart_tx_pkg::tx_host_wr_t wr,
    output logic                     wr_ack,
    output logic                     tx,
    output logic                     busy
);

    uart_tx_pkg::tx_byte_t    rd_data;
    uart_tx_pkg::tx_dp_ctrl_t dp_ctrl;
    logic                     empty;
    logic                     read_en;
    logic                     counter_clear;
    logic                     count_reached;

    // Host side buffering
    uart_tx_fifo u_fifo (
        .clk     (clk),
        .reset_b (reset_b),
        .wr      (wr),
        .wr_ack  (wr_ack),
        .read_en (read_en),
        .rd_data (rd_data),
        .empty   (empty)
    );

    uart_tx_controller u_controller (
        .clk           (clk),
        .reset_b       (reset_b),
        .empty         (empty),
        .count_reached (count_reached),
        .read_en       (read_en),
        .counter_clear (counter_clear),
        .ctrl          (dp_ctrl),
        .busy          (busy)
    );

    uart_baud_counter u_baud_counter (
        .clk           (clk),
        .reset_b       (reset_b),
        .counter_clear (counter_clear),
        .count_reached (count_reached)
    );

    // Serial line driver
    uart_tx_datapath u_datapath (
        .clk     (clk),
        .reset_b (reset_b),
        .ctrl    (dp_ctrl),
        .rd_data (rd_data),
        .tx      (tx)
    );

endmodule

//--- uart_tx_controller.sv
// ======================================
// UART transmit frame controller
// ======================================
`timescale 1ns/1ps

module uart_tx_controller (
    input  logic                     clk,
    input  logic                     reset_b,
    input  logic                     empty,
    input  logic                     count_reached,
    output logic                     read_en,
    output logic                     counter_clear,
    output uart_tx_pkg::tx_dp_ctrl_t ctrl,
    output logic                     busy
);

    uart_tx_pkg::tx_state_t state;
    uart_tx_pkg::tx_state_t next_state;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= uart_tx_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign busy = (state != uart_tx_pkg::IDLE);

    always_comb begin
        // Idle line, counter running, nothing fetched unless a state says so
        next_state    = state;
        read_en       = 1'b0;
        counter_clear = 1'b0;
        ctrl.bit_sel  = uart_tx_pkg::STOP_BIT;
        ctrl.capture  = 1'b0;
        case (state)
            uart_tx_pkg::IDLE: begin
                counter_clear = 1'b1;
                if (!empty) begin
                    next_state = uart_tx_pkg::READ_EN;
                end
            end
            uart_tx_pkg::READ_EN: begin
                counter_clear = 1'b1;
                read_en       = 1'b1;  // Pop the FIFO head
                next_state    = uart_tx_pkg::WAIT;
            end
            uart_tx_pkg::WAIT: begin
                counter_clear = 1'b1;
                ctrl.capture  = 1'b1;  // rd_data is valid now
                next_state    = uart_tx_pkg::START;
            end
            // From here on every state lasts one full bit period
            uart_tx_pkg::START: begin
                ctrl.bit_sel = uart_tx_pkg::START_BIT;
                if (count_reached) begin
                    next_state = uart_tx_pkg::D0;
                end
            end
            uart_tx_pkg::D0: begin
                ctrl.bit_sel = uart_tx_pkg::DATA_0;
                if (count_reached) begin
                    next_state = uart_tx_pkg::D1;
                end
            end
            uart_tx_pkg::D1: begin
                ctrl.bit_sel = uart_tx_pkg::DATA_1;
                if (count_reached) begin
                    next_state = uart_tx_pkg::D2;
                end
            end
            uart_tx_pkg::D2: begin
                ctrl.bit_sel = uart_tx_pkg::DATA_2;
                if (count_reached) begin
                    next_state = uart_tx_pkg::D3;
                end
            end
            uart_tx_pkg::D3: begin
                ctrl.bit_sel = uart_tx_pkg::DATA_3;
                if (count_reached) begin
                    next_state = uart_tx_pkg::D4;
                end
            end
            uart_tx_pkg::D4: begin
                ctrl.bit_sel = uart_tx_pkg::DATA_4;
                if (count_reached) begin
                    next_state = uart_tx_pkg::D5;
                end
            end
            uart_tx_pkg::D5: begin
                ctrl.bit_sel = uart_tx_pkg::DATA_5;
                if (count_reached) begin
                    next_state = uart_tx_pkg::D6;
                end
            end
            uart_tx_pkg::D6: begin
                ctrl.bit_sel = uart_tx_pkg::DATA_6;
                if (count_reached) begin
                    next_state = uart_tx_pkg::D7;
                end
            end
            uart_tx_pkg::D7: begin
                ctrl.bit_sel = uart_tx_pkg::DATA_7;
                if (count_reached) begin
                    next_state = uart_tx_pkg::STOP;
                end
            end
            uart_tx_pkg::STOP: begin
                if (count_reached) begin
                    next_state = uart_tx_pkg::IDLE;  // Fetch cycles follow before the next start
                end
            end
            default: begin
                // Unused encodings recover straight to IDLE
                counter_clear = 1'b1;
                next_state    = uart_tx_pkg::IDLE;
            end
        endcase
    end

endmodule

//--- uart_tx_datapath.sv
// ======================================
// UART transmit datapath
// ======================================
`timescale 1ns/1ps

module uart_tx_datapath (
    input  logic                     clk,
    input  logic                     reset_b,
    input  uart_tx_pkg::tx_dp_ctrl_t ctrl,
    input  uart_tx_pkg::tx_byte_t    rd_data,
    output logic                     tx
);

    uart_tx_pkg::tx_byte_t held_byte;
    logic                  line_bit;

    // Byte stays put for the whole frame once captured
    always_ff @(posedge clk) begin
        if (ctrl.capture) begin
            held_byte <= rd_data;
        end
    end

    always_comb begin
        case (ctrl.bit_sel)
            uart_tx_pkg::START_BIT: line_bit = 1'b0;
            uart_tx_pkg::DATA_0:    line_bit = held_byte[0];
            uart_tx_pkg::DATA_1:    line_bit = held_byte[1];
            uart_tx_pkg::DATA_2:    line_bit = held_byte[2];
            uart_tx_pkg::DATA_3:    line_bit = held_byte[3];
            uart_tx_pkg::DATA_4:    line_bit = held_byte[4];
            uart_tx_pkg::DATA_5:    line_bit = held_byte[5];
            uart_tx_pkg::DATA_6:    line_bit = held_byte[6];
            uart_tx_pkg::DATA_7:    line_bit = held_byte[7];
            default:                line_bit = 1'b1;  // Stop bit and idle
        endcase
    end

    // Registered so the serial line is glitch free
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            tx <= 1'b1;
        end else begin
            tx <= line_bit;
        end
    end

endmodule

//--- uart_baud_counter.sv
// ======================================
// UART bit period counter
// ======================================
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module uart_baud_counter (
    input  logic clk,
    input  logic reset_b,
    input  logic counter_clear,
    output logic count_reached
);

    localparam int LAST_COUNT = `UART_CLKS_PER_BIT - 1;

    logic [`UART_CNT_W-1:0] count;
    logic                   wrap;

    assign wrap          = (count == LAST_COUNT[`UART_CNT_W-1:0]);
    assign count_reached = wrap && !counter_clear;  // Last cycle of the current bit

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            count <= '0;
        end else if (counter_clear || wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- uart_tx_fifo.sv
// ======================================
// UART transmit byte FIFO
// ======================================
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module uart_tx_fifo (
    input  logic                   clk,
    input  logic                   reset_b,
    input  uart_tx_pkg::tx_host_wr_t wr,
    output logic                   wr_ack,
    input  logic                   read_en,
    output uart_tx_pkg::tx_byte_t  rd_data,
    output logic                   empty
);

    uart_tx_pkg::tx_byte_t mem [`UART_FIFO_DEPTH];

    // One extra pointer bit separates full from empty
    logic [`UART_FIFO_AW:0] wr_ptr;
    logic [`UART_FIFO_AW:0] rd_ptr;
    logic                   ack_q;
    logic                   full;
    logic                   wr_fire;
    logic                   rd_fire;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`UART_FIFO_AW] != rd_ptr[`UART_FIFO_AW]) &&
                   (wr_ptr[`UART_FIFO_AW-1:0] == rd_ptr[`UART_FIFO_AW-1:0]);

    // A request is taken once, and only after the previous ack has dropped
    assign wr_fire = wr.req && !ack_q && !full;
    assign rd_fire = read_en && !empty;
    assign wr_ack  = ack_q;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ack_q  <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_fire) begin
                ack_q <= 1'b1;
            end else if (!wr.req) begin
                ack_q <= 1'b0;  // Host has released req, close the handshake
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr[`UART_FIFO_AW-1:0]] <= wr.data;
        end
        if (rd_fire) begin
            rd_data <= mem[rd_ptr[`UART_FIFO_AW-1:0]];  // Head shows up the cycle after read_en
        end
    end

endmodule

//--- uart_tx_pkg.sv
// ======================================
// UART transmitter types
// ======================================
package uart_tx_pkg;

    typedef logic [7:0] tx_byte_t;

    // Line value select, STOP_BIT doubles as the idle level
    typedef enum logic [3:0] {
        START_BIT = 4'd0,
        DATA_0    = 4'd1,
        DATA_1    = 4'd2,
        DATA_2    = 4'd3,
        DATA_3    = 4'd4,
        DATA_4    = 4'd5,
        DATA_5    = 4'd6,
        DATA_6    = 4'd7,
        DATA_7    = 4'd8,
        STOP_BIT  = 4'd9
    } tx_bit_sel_t;

    typedef enum logic [3:0] {
        IDLE    = 4'd0,
        START   = 4'd1,
        D0      = 4'd2,
        D1      = 4'd3,
        D2      = 4'd4,
        D3      = 4'd5,
        D4      = 4'd6,
        D5      = 4'd7,
        D6      = 4'd8,
        D7      = 4'd9,
        STOP    = 4'd10,
        READ_EN = 4'd11,
        WAIT    = 4'd12
    } tx_state_t;

    typedef struct packed {
        tx_bit_sel_t bit_sel;
        logic        capture;  // Load the FIFO head into the datapath
    } tx_dp_ctrl_t;

    typedef struct packed {
        logic     req;
        tx_byte_t data;
    } tx_host_wr_t;

endpackage

//--- uart_tx_macros.svh
// ======================================
// UART transmitter sizing
// ======================================
`ifndef UART_TX_MACROS_SVH
`define UART_TX_MACROS_SVH

// Clock cycles spent on every serial bit, start and stop included
`define UART_CLKS_PER_BIT 8
`define UART_CNT_W ($clog2(`UART_CLKS_PER_BIT))  // Baud counter width

// Bytes held by the host write FIFO, a power of two
`define UART_FIFO_DEPTH 4
`define UART_FIFO_AW ($clog2(`UART_FIFO_DEPTH))  // FIFO address width

`endif
